// ==== rtl/bpu_config.svh ====
`ifndef BPU_CONFIG_SVH
`define BPU_CONFIG_SVH

// sizing of the branch-prediction unit

// virtual address width
`define BPU_ADDR_BITS 32

// direct-mapped table index, taken from pc[11:2]
`define BPU_INDEX_BITS 10

// tag above the index, pc[31:12]
`define BPU_TAG_BITS 20

// lowest pc bit used by the index
// instructions are word aligned
`define BPU_INDEX_LSB 2

// a fetch group holds two instructions
// so fall-through is eight bytes ahead
`define BPU_FETCH_STEP 8

// size of one instruction in bytes
`define BPU_INST_BYTES 4

// return stack entries, power of two so pointers wrap
`define BPU_RAS_DEPTH 8

`endif

// ==== rtl/bpu_pkg.sv ====
`include "bpu_config.svh"

package bpu_pkg;

    // virtual address as seen by fetch and execute
    typedef logic [`BPU_ADDR_BITS-1:0] bpu_addr_t;

    // two-bit saturating counter
    typedef logic [1:0] bpu_count_t;

    // branch kind stored in each table entry
    // branch_none marks an empty entry
    typedef enum logic [2:0] {
        branch_none   = 3'd0,
        branch_cond   = 3'd1,
        branch_jump   = 3'd2,
        branch_call   = 3'd3,
        branch_return = 3'd4
    } br_type_t;

    // correction sequence after a mispredict
    typedef enum logic {
        state_idle       = 1'b0,
        state_correction = 1'b1
    } bpu_state_t;

    // counter encodings
    // bit 1 set means predict taken
    localparam bpu_count_t cnt_strong_nt = 2'd0;
    localparam bpu_count_t cnt_weak_nt   = 2'd1;
    localparam bpu_count_t cnt_weak_t    = 2'd2;
    localparam bpu_count_t cnt_strong_t  = 2'd3;

endpackage

// ==== rtl/branch_predictor.sv ====
`include "bpu_config.svh"

module branch_predictor import bpu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       exception,

    // lookup request from fetch
    input  logic       fetch_valid,
    input  bpu_addr_t  fetch_pc,

    // resolved branch from execute
    input  logic       verify_valid,
    input  bpu_addr_t  verify_pc,
    input  logic       verify_success,
    input  logic       verify_taken,
    input  bpu_addr_t  verify_target,
    input  br_type_t   verify_br_type,
    input  bpu_count_t verify_count,
    input  logic       verify_inst2,

    // prediction back to fetch
    output logic       pred_valid,
    output logic       pred_taken,
    output bpu_addr_t  pred_target,
    output br_type_t   pred_br_type,
    output bpu_count_t pred_count,
    output logic       pred_inst2,

    // one-cycle redirect after a mispredict
    output logic       correction_valid,
    output bpu_addr_t  correction_target
);

    localparam int tag_lsb = `BPU_ADDR_BITS - `BPU_TAG_BITS;
    localparam int idx_msb = `BPU_INDEX_LSB + `BPU_INDEX_BITS - 1;

    // table read side
    logic [`BPU_INDEX_BITS-1:0] rd_index;
    logic [`BPU_TAG_BITS-1:0]   rd_tag;
    br_type_t                   rd_br_type;
    bpu_addr_t                  rd_target;
    bpu_count_t                 rd_count;
    logic                       rd_inst2;
    logic                       hit;

    // table write side
    logic [`BPU_INDEX_BITS-1:0] wr_index;
    logic [`BPU_TAG_BITS-1:0]   wr_tag;
    bpu_count_t                 trained_count;

    // stack control
    logic                       spec_push;
    logic                       spec_pop;
    bpu_addr_t                  spec_push_data;
    logic                       commit_push;
    logic                       commit_pop;
    bpu_addr_t                  ras_top;

    bpu_addr_t                  fall_through;
    bpu_state_t                 state;
    logic                       mispredict;

    // fetch side address split
    assign rd_index = fetch_pc[idx_msb:`BPU_INDEX_LSB];
    assign hit      = (rd_tag == fetch_pc[`BPU_ADDR_BITS-1:tag_lsb]);

    // verify side address split
    assign wr_index = verify_pc[idx_msb:`BPU_INDEX_LSB];
    assign wr_tag   = verify_pc[`BPU_ADDR_BITS-1:tag_lsb];

    branch_target_table branch_target_table_i (
        .clk        (clk),
        .reset      (reset),
        .rd_index   (rd_index),
        .rd_tag     (rd_tag),
        .rd_br_type (rd_br_type),
        .rd_target  (rd_target),
        .rd_count   (rd_count),
        .rd_inst2   (rd_inst2),
        .wr_en      (verify_valid),
        .wr_index   (wr_index),
        .wr_tag     (wr_tag),
        .wr_br_type (verify_br_type),
        .wr_target  (verify_target),
        .wr_count   (trained_count),
        .wr_inst2   (verify_inst2)
    );

    assign fall_through = fetch_pc + bpu_addr_t'(`BPU_FETCH_STEP);

    // no prediction while the redirect is pending
    assign pred_valid = fetch_valid && (state == state_idle) && hit
                        && (rd_br_type != branch_none);

    // entry fields go back to fetch on a hit, so execute can train them
    // a miss reports an empty entry with a weak not-taken count
    assign pred_br_type = hit ? rd_br_type : branch_none;
    assign pred_count   = hit ? rd_count : cnt_weak_nt;
    assign pred_inst2   = hit && rd_inst2;

    // direction and target
    always_comb begin
        pred_taken  = 1'b0;
        pred_target = fall_through;
        if (pred_valid) begin
            case (rd_br_type)
                branch_call, branch_jump: begin
                    pred_taken  = 1'b1;
                    pred_target = rd_target;
                end
                branch_return: begin
                    pred_taken  = 1'b1;
                    pred_target = ras_top;
                end
                branch_cond: begin
                    // upper counter bit is the taken vote
                    pred_taken  = rd_count[1];
                    pred_target = rd_count[1] ? rd_target : fall_through;
                end
                default: begin
                    pred_taken  = 1'b0;
                    pred_target = fall_through;
                end
            endcase
        end
    end

    // counter training
    // a wrong guess restarts at the weak side of the real outcome
    always_comb begin
        if (!verify_success) begin
            trained_count = verify_taken ? cnt_weak_t : cnt_weak_nt;
        end else if (verify_taken) begin
            trained_count = (verify_count == cnt_strong_t) ? cnt_strong_t
                                                           : verify_count + 2'd1;
        end else begin
            trained_count = (verify_count == cnt_strong_nt) ? cnt_strong_nt
                                                            : verify_count - 2'd1;
        end
    end

    // speculative stack follows live predictions
    // call returns past its own group, four bytes more if inst2
    assign spec_push      = pred_valid && (rd_br_type == branch_call);
    assign spec_pop       = pred_valid && (rd_br_type == branch_return);
    assign spec_push_data = rd_inst2 ? fall_through + bpu_addr_t'(`BPU_INST_BYTES)
                                     : fall_through;

    // committed stack follows verified branches
    assign commit_push = verify_valid && (verify_br_type == branch_call);
    assign commit_pop  = verify_valid && (verify_br_type == branch_return);

    return_stack return_stack_i (
        .clk              (clk),
        .reset            (reset),
        .flush            (flush),
        .push             (spec_push),
        .pop              (spec_pop),
        .push_data        (spec_push_data),
        .commit_push      (commit_push),
        .commit_pop       (commit_pop),
        .commit_push_data (verify_pc + bpu_addr_t'(`BPU_FETCH_STEP)),
        .top              (ras_top)
    );

    // correction FSM
    assign mispredict = verify_valid && !verify_success;

    always_ff @(posedge clk) begin
        if (reset || exception) begin
            state <= state_idle;
        end else if (state == state_correction) begin
            // redirect lasts a single cycle
            state <= state_idle;
        end else if (mispredict) begin
            state <= state_correction;
        end
    end

    // later mispredicts during correction are dropped
    always_ff @(posedge clk) begin
        if (mispredict && (state == state_idle)) begin
            correction_target <= verify_target;
        end
    end

    assign correction_valid = (state == state_correction);

endmodule

// ==== rtl/branch_target_table.sv ====
`include "bpu_config.svh"

module branch_target_table import bpu_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,

    // lookup port, answered in the same cycle
    input  logic [`BPU_INDEX_BITS-1:0] rd_index,
    output logic [`BPU_TAG_BITS-1:0]   rd_tag,
    output br_type_t                   rd_br_type,
    output bpu_addr_t                  rd_target,
    output bpu_count_t                 rd_count,
    output logic                       rd_inst2,

    // update port from execute
    input  logic                       wr_en,
    input  logic [`BPU_INDEX_BITS-1:0] wr_index,
    input  logic [`BPU_TAG_BITS-1:0]   wr_tag,
    input  br_type_t                   wr_br_type,
    input  bpu_addr_t                  wr_target,
    input  bpu_count_t                 wr_count,
    input  logic                       wr_inst2
);

    localparam int depth = 1 << `BPU_INDEX_BITS;

    // one array per field
    // only the type array is cleared, it alone marks an entry as live
    logic [`BPU_TAG_BITS-1:0] tag_mem    [depth];
    br_type_t                 type_mem   [depth];
    bpu_addr_t                target_mem [depth];
    bpu_count_t               count_mem  [depth];
    logic                     inst2_mem  [depth];

    // zero-latency read
    // no bypass, a same-cycle write shows up next cycle
    assign rd_tag     = tag_mem[rd_index];
    assign rd_br_type = type_mem[rd_index];
    assign rd_target  = target_mem[rd_index];
    assign rd_count   = count_mem[rd_index];
    assign rd_inst2   = inst2_mem[rd_index];

    // type field, empties the whole table on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                type_mem[i] <= branch_none;
            end
        end else if (wr_en) begin
            type_mem[wr_index] <= wr_br_type;
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]    <= wr_tag;
            target_mem[wr_index] <= wr_target;
            count_mem[wr_index]  <= wr_count;
            inst2_mem[wr_index]  <= wr_inst2;
        end
    end

endmodule

// ==== rtl/return_stack.sv ====
`include "bpu_config.svh"

module return_stack import bpu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,

    // speculative side, driven by predictions
    input  logic      push,
    input  logic      pop,
    input  bpu_addr_t push_data,

    // committed side, driven by verified branches
    input  logic      commit_push,
    input  logic      commit_pop,
    input  bpu_addr_t commit_push_data,

    output bpu_addr_t top
);

    localparam int ptr_bits = $clog2(`BPU_RAS_DEPTH);

    // circular storage, overflow silently overwrites the oldest entry
    bpu_addr_t spec_mem   [`BPU_RAS_DEPTH];
    bpu_addr_t commit_mem [`BPU_RAS_DEPTH];

    // pointers address the next free slot
    logic [ptr_bits-1:0] spec_ptr;
    logic [ptr_bits-1:0] commit_ptr;
    logic [ptr_bits-1:0] spec_top_idx;
    logic [ptr_bits-1:0] commit_top_idx;

    // pointer step shared by both copies
    // push and pop together leave the pointer alone
    function automatic logic [ptr_bits-1:0] next_ptr(
        input logic [ptr_bits-1:0] ptr,
        input logic                do_push,
        input logic                do_pop
    );
        logic [ptr_bits-1:0] result;
        result = ptr;
        if (do_push && !do_pop) begin
            result = ptr + 1'b1;
        end else if (do_pop && !do_push) begin
            result = ptr - 1'b1;
        end
        return result;
    endfunction

    // entry just below each pointer
    assign spec_top_idx   = spec_ptr - 1'b1;
    assign commit_top_idx = commit_ptr - 1'b1;

    assign top = spec_mem[spec_top_idx];

    // speculative pointer
    // flush takes the committed pointer as it stands this cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            spec_ptr <= '0;
        end else if (flush) begin
            spec_ptr <= commit_ptr;
        end else begin
            spec_ptr <= next_ptr(spec_ptr, push, pop);
        end
    end

    // speculative entries
    always_ff @(posedge clk) begin
        if (flush) begin
            spec_mem <= commit_mem;
        end else if (push && pop) begin
            // return and call in one step, top is replaced
            spec_mem[spec_top_idx] <= push_data;
        end else if (push) begin
            spec_mem[spec_ptr] <= push_data;
        end
    end

    // committed pointer, never disturbed by flush
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_ptr <= '0;
        end else begin
            commit_ptr <= next_ptr(commit_ptr, commit_push, commit_pop);
        end
    end

    // committed entries
    always_ff @(posedge clk) begin
        if (commit_push && commit_pop) begin
            commit_mem[commit_top_idx] <= commit_push_data;
        end else if (commit_push) begin
            commit_mem[commit_ptr] <= commit_push_data;
        end
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_branch_predictor -f verilog.f \
    && ./obj_dir/Vtb_branch_predictor | tee sim.log \
    || echo "build or simulation did not complete"
# the log decides the result
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

// ==== testbench/bpu_properties.sv ====
module bpu_properties (
    input logic clk,
    input logic reset,
    input logic pred_valid,
    input logic correction_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    // redirect is a single-cycle pulse
    single_redirect: assert property (
        @(posedge clk) disable iff (reset) correction_valid |=> !correction_valid
    ) else $error("correction_valid high on two consecutive cycles");

    // fetch gets no prediction while the redirect is out
    quiet_during_redirect: assert property (
        @(posedge clk) disable iff (reset) correction_valid |-> !pred_valid
    ) else $error("pred_valid high together with correction_valid");

    // reset leaves the correction FSM idle
    idle_after_reset: assert property (
        @(posedge clk) reset |=> !correction_valid
    ) else $error("correction_valid high right after reset");

endmodule

bind branch_predictor bpu_properties bpu_properties_i (
    .clk              (clk),
    .reset            (reset),
    .pred_valid       (pred_valid),
    .correction_valid (correction_valid)
);

// ==== testbench/tb_branch_predictor.sv ====
module tb_branch_predictor import bpu_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 2000;

    logic clk, reset, flush, exception, fetch_valid, verify_valid;
    logic verify_success, verify_taken, verify_inst2;
    bpu_addr_t fetch_pc, verify_pc, verify_target, pred_target, correction_target;
    br_type_t verify_br_type, pred_br_type;
    bpu_count_t verify_count, pred_count;
    logic pred_valid, pred_taken, pred_inst2, correction_valid;

    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    integer seed = 32'hcd58182a;

    // reference model of table, stacks and correction state
    br_type_t   m_type   [1024];
    logic [19:0] m_tag   [1024];
    bpu_addr_t  m_target [1024];
    bpu_count_t m_count  [1024];
    logic       m_inst2  [1024];
    bpu_addr_t  spec_q   [$];
    bpu_addr_t  commit_q [$];
    logic       m_corr;
    bpu_addr_t  m_corr_target;

    branch_predictor branch_predictor_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hard stop if a test never returns
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // saturating two-bit counter
    // a miss restarts at the weak side of the outcome
    function automatic bpu_count_t train(input bpu_count_t count, input logic success,
                                         input logic taken);
        if (!success) begin
            return taken ? cnt_weak_t : cnt_weak_nt;
        end
        if (taken) begin
            return (count == cnt_strong_t) ? count : count + 2'd1;
        end
        return (count == cnt_strong_nt) ? count : count - 2'd1;
    endfunction

    // strobes default low and callers override them
    task automatic start_cycle();
        @(posedge clk);
        fetch_valid <= 1'b0;
        verify_valid <= 1'b0;
        flush <= 1'b0;
        exception <= 1'b0;
    endtask

    // check at the falling edge and then advance the model past the next edge
    task automatic finish_cycle();
        logic [9:0] idx;
        logic [9:0] widx;
        logic exp_valid;
        logic exp_taken;
        bpu_addr_t exp_target;
        @(negedge clk);
        idx = fetch_pc[11:2];
        widx = verify_pc[11:2];
        exp_valid = fetch_valid && !m_corr && (m_type[idx] != branch_none)
                    && (m_tag[idx] == fetch_pc[31:12]);
        exp_taken = 1'b0;
        exp_target = fetch_pc + 32'd8;
        if (exp_valid && m_type[idx] == branch_return) begin
            exp_taken = 1'b1;
            exp_target = spec_q[$];
        end else if (exp_valid && (m_type[idx] != branch_cond || m_count[idx][1])) begin
            exp_taken = 1'b1;
            exp_target = m_target[idx];
        end
        check_value(32'(pred_valid), 32'(exp_valid), "pred_valid");
        check_value(32'(pred_taken), 32'(exp_taken), "pred_taken");
        check_value(pred_target, exp_target, "pred_target");
        if (exp_valid) begin
            check_value(32'(pred_br_type), 32'(m_type[idx]), "pred_br_type");
            check_value(32'(pred_count), 32'(m_count[idx]), "pred_count");
            check_value(32'(pred_inst2), 32'(m_inst2[idx]), "pred_inst2");
        end
        check_value(32'(correction_valid), 32'(m_corr), "correction_valid");
        if (m_corr) begin
            check_value(correction_target, m_corr_target, "correction_target");
        end
        // flush beats speculative traffic and sees the old committed copy
        if (flush) begin
            spec_q = commit_q;
        end else if (exp_valid && m_type[idx] == branch_call) begin
            spec_q.push_back(fetch_pc + (m_inst2[idx] ? 32'd12 : 32'd8));
        end else if (exp_valid && m_type[idx] == branch_return) begin
            void'(spec_q.pop_back());
        end
        if (verify_valid) begin
            if (verify_br_type == branch_call) begin
                commit_q.push_back(verify_pc + 32'd8);
            end else if (verify_br_type == branch_return) begin
                void'(commit_q.pop_back());
            end
            m_type[widx] = verify_br_type;
            m_tag[widx] = verify_pc[31:12];
            m_target[widx] = verify_target;
            m_inst2[widx] = verify_inst2;
            m_count[widx] = train(verify_count, verify_success, verify_taken);
        end
        if (exception || m_corr) begin
            m_corr = 1'b0;
        end else if (verify_valid && !verify_success) begin
            m_corr = 1'b1;
            m_corr_target = verify_target;
        end
    endtask

    task automatic drive_idle();
        start_cycle();
        finish_cycle();
    endtask

    task automatic drive_lookup(input bpu_addr_t pc);
        start_cycle();
        fetch_valid <= 1'b1;
        fetch_pc <= pc;
        finish_cycle();
    endtask

    // predicted count comes back from the model entry
    task automatic load_verify(input bpu_addr_t pc, input logic success, input logic taken,
                               input bpu_addr_t target, input br_type_t kind,
                               input logic inst2);
        verify_valid <= 1'b1;
        verify_pc <= pc;
        verify_success <= success;
        verify_taken <= taken;
        verify_target <= target;
        verify_br_type <= kind;
        verify_count <= m_count[pc[11:2]];
        verify_inst2 <= inst2;
    endtask

    task automatic drive_verify(input bpu_addr_t pc, input logic success, input logic taken,
                                input bpu_addr_t target, input br_type_t kind,
                                input logic inst2);
        start_cycle();
        load_verify(pc, success, taken, target, kind, inst2);
        finish_cycle();
    endtask

    task automatic test_reset_misses();
        bpu_addr_t pc;
        for (int i = 0; i < 20; i++) begin
            pc = $random(seed);
            drive_lookup(pc);
            check_value(32'(pred_valid), 32'd0, "empty table hit");
        end
    endtask

    task automatic test_mispredict_jump();
        drive_verify(32'h0000_1040, 1'b0, 1'b1, 32'h0000_2000, branch_jump, 1'b0);
        drive_idle();
        check_value(32'(correction_valid), 32'd1, "redirect after mispredict");
        check_value(correction_target, 32'h0000_2000, "redirect target");
        drive_lookup(32'h0000_1040);
        check_value(32'(correction_valid), 32'd0, "redirect width");
        check_value(32'(pred_taken), 32'd1, "jump taken");
        check_value(pred_target, 32'h0000_2000, "jump target");
    endtask

    // each step is {success, taken, expected count}
    task automatic test_cond_training();
        logic [3:0] steps [9] = '{4'b0110, 4'b1111, 4'b1111, 4'b1010, 4'b1001,
                                  4'b1000, 4'b1000, 4'b0110, 4'b0001};
        for (int i = 0; i < 9; i++) begin
            drive_verify(32'h0000_3100, steps[i][3], steps[i][2], 32'h0000_3800,
                         branch_cond, 1'b0);
            drive_idle();
            drive_lookup(32'h0000_3100);
            check_value(32'(pred_count), 32'(steps[i][1:0]), "trained count");
            check_value(32'(pred_taken), 32'(steps[i][1]), "cond direction");
        end
    endtask

    task automatic test_call_return();
        // two calls and a return go into the table and the committed stack
        drive_verify(32'h0000_4000, 1'b1, 1'b1, 32'h0000_5000, branch_call, 1'b0);
        drive_verify(32'h0000_5010, 1'b1, 1'b1, 32'h0000_6000, branch_call, 1'b1);
        drive_verify(32'h0000_6020, 1'b1, 1'b1, 32'h0000_4008, branch_return, 1'b0);
        drive_lookup(32'h0000_4000);
        drive_lookup(32'h0000_5010);
        drive_lookup(32'h0000_6020);
        check_value(pred_target, 32'h0000_501c, "inner return with inst2");
        drive_lookup(32'h0000_6020);
        check_value(pred_target, 32'h0000_4008, "outer return");
    endtask

    task automatic test_flush_restore();
        drive_verify(32'h0000_7200, 1'b1, 1'b1, 32'h0000_5000, branch_call, 1'b0);
        // speculative calls that never commit
        // one deeper than the committed stack
        drive_lookup(32'h0000_4000);
        drive_lookup(32'h0000_5010);
        drive_lookup(32'h0000_4000);
        start_cycle();
        flush <= 1'b1;
        finish_cycle();
        drive_lookup(32'h0000_6020);
        check_value(pred_target, 32'h0000_7208, "return after flush");
    endtask

    task automatic test_exception_exit();
        // exception in the mispredict cycle keeps the FSM idle
        start_cycle();
        load_verify(32'h0000_1040, 1'b0, 1'b1, 32'h0000_2400, branch_jump, 1'b0);
        exception <= 1'b1;
        finish_cycle();
        drive_lookup(32'h0000_1040);
        check_value(32'(pred_valid), 32'd1, "lookup after exception");
        check_value(32'(correction_valid), 32'd0, "correction after exception");
        check_value(pred_target, 32'h0000_2400, "retrained jump target");
    endtask

    initial begin
        reset = 1'b1;
        flush = 1'b0;
        exception = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        verify_valid = 1'b0;
        verify_pc = '0;
        verify_success = 1'b0;
        verify_taken = 1'b0;
        verify_target = '0;
        verify_br_type = branch_none;
        verify_count = cnt_weak_nt;
        verify_inst2 = 1'b0;
        // model starts from the reset state
        for (int i = 0; i < 1024; i++) begin
            m_type[i] = branch_none;
            m_count[i] = cnt_weak_nt;
        end
        m_corr = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        test_reset_misses();
        test_mispredict_jump();
        test_cond_training();
        test_call_return();
        test_flush_restore();
        test_exception_exit();
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/bpu_pkg.sv
rtl/branch_target_table.sv
rtl/return_stack.sv
rtl/branch_predictor.sv
testbench/bpu_properties.sv
testbench/tb_branch_predictor.sv
